/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsdom_fabric
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module lsdom_fabric -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* lsdom_decoder.sv */
`include "lsdom_settings.svh"

module lsdom_decoder (
    input  logic             req_valid,
    output logic             req_ready,
    input  lsdom_pkg::addr_t req_addr,
    input  logic             req_we,
    input  lsdom_pkg::data_t req_wdata,
    input  lsdom_pkg::strb_t req_strb,
    lsdom_req_if.decoder     dec
);
    import lsdom_pkg::*;

    function automatic logic in_region(addr_t addr, addr_t base, addr_t limit);
        return (addr >= base) && (addr < limit);
    endfunction

    // Handshake and payload go straight to the router
    assign dec.valid = req_valid;
    assign req_ready = dec.ready;
    assign dec.we    = req_we;
    assign dec.wdata = req_wdata;
    assign dec.strb  = req_strb;

    always_comb begin
        if (in_region(req_addr, addr_t'(`LSDOM_MEM_BASE), addr_t'(`LSDOM_MEM_END))) begin
            dec.target = TGT_MEM;
            dec.addr   = req_addr - addr_t'(`LSDOM_MEM_BASE);
        end else if (in_region(req_addr, addr_t'(`LSDOM_SYSCFG_BASE),
                               addr_t'(`LSDOM_SYSCFG_END))) begin
            dec.target = TGT_SYSCFG;
            dec.addr   = req_addr - addr_t'(`LSDOM_SYSCFG_BASE);
        end else if (in_region(req_addr, addr_t'(`LSDOM_LSP_BASE),
                               addr_t'(`LSDOM_LSP_END))) begin
            dec.target = TGT_LSP;
            dec.addr   = req_addr - addr_t'(`LSDOM_LSP_BASE);
        end else begin
            // Unmapped, router answers with an error
            dec.target = TGT_NONE;
            dec.addr   = req_addr;
        end
    end

endmodule

/* lsdom_fabric.sv */
module lsdom_fabric (
    input  logic             clk,
    input  logic             rst_n,

    // Initiator 0
    input  logic             cpu0_req_valid,
    output logic             cpu0_req_ready,
    input  lsdom_pkg::addr_t cpu0_req_addr,
    input  logic             cpu0_req_we,
    input  lsdom_pkg::data_t cpu0_req_wdata,
    input  lsdom_pkg::strb_t cpu0_req_strb,
    output logic             cpu0_rsp_valid,
    input  logic             cpu0_rsp_ready,
    output lsdom_pkg::data_t cpu0_rsp_rdata,
    output logic             cpu0_rsp_err,

    // Initiator 1
    input  logic             cpu1_req_valid,
    output logic             cpu1_req_ready,
    input  lsdom_pkg::addr_t cpu1_req_addr,
    input  logic             cpu1_req_we,
    input  lsdom_pkg::data_t cpu1_req_wdata,
    input  lsdom_pkg::strb_t cpu1_req_strb,
    output logic             cpu1_rsp_valid,
    input  logic             cpu1_rsp_ready,
    output lsdom_pkg::data_t cpu1_rsp_rdata,
    output logic             cpu1_rsp_err,

    // Local memory
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output lsdom_pkg::addr_t mem_req_addr,
    output logic             mem_req_we,
    output lsdom_pkg::data_t mem_req_wdata,
    output lsdom_pkg::strb_t mem_req_strb,
    input  logic             mem_rsp_valid,
    input  lsdom_pkg::data_t mem_rsp_rdata,
    input  logic             mem_rsp_err,

    // System configuration
    output logic             syscfg_req_valid,
    input  logic             syscfg_req_ready,
    output lsdom_pkg::addr_t syscfg_req_addr,
    output logic             syscfg_req_we,
    output lsdom_pkg::data_t syscfg_req_wdata,
    output lsdom_pkg::strb_t syscfg_req_strb,
    input  logic             syscfg_rsp_valid,
    input  lsdom_pkg::data_t syscfg_rsp_rdata,
    input  logic             syscfg_rsp_err,

    // Low-speed peripherals
    output logic             lsp_req_valid,
    input  logic             lsp_req_ready,
    output lsdom_pkg::addr_t lsp_req_addr,
    output logic             lsp_req_we,
    output lsdom_pkg::data_t lsp_req_wdata,
    output lsdom_pkg::strb_t lsp_req_strb,
    input  logic             lsp_rsp_valid,
    input  lsdom_pkg::data_t lsp_rsp_rdata,
    input  logic             lsp_rsp_err
);

    lsdom_req_if dec0_if ();
    lsdom_req_if dec1_if ();

    lsdom_decoder dec0_i (
        .req_valid (cpu0_req_valid),
        .req_ready (cpu0_req_ready),
        .req_addr  (cpu0_req_addr),
        .req_we    (cpu0_req_we),
        .req_wdata (cpu0_req_wdata),
        .req_strb  (cpu0_req_strb),
        .dec       (dec0_if.decoder)
    );

    lsdom_decoder dec1_i (
        .req_valid (cpu1_req_valid),
        .req_ready (cpu1_req_ready),
        .req_addr  (cpu1_req_addr),
        .req_we    (cpu1_req_we),
        .req_wdata (cpu1_req_wdata),
        .req_strb  (cpu1_req_strb),
        .dec       (dec1_if.decoder)
    );

    lsdom_router router_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec0             (dec0_if.router),
        .dec1             (dec1_if.router),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .mem_req_addr     (mem_req_addr),
        .mem_req_we       (mem_req_we),
        .mem_req_wdata    (mem_req_wdata),
        .mem_req_strb     (mem_req_strb),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_rdata    (mem_rsp_rdata),
        .mem_rsp_err      (mem_rsp_err),
        .syscfg_req_valid (syscfg_req_valid),
        .syscfg_req_ready (syscfg_req_ready),
        .syscfg_req_addr  (syscfg_req_addr),
        .syscfg_req_we    (syscfg_req_we),
        .syscfg_req_wdata (syscfg_req_wdata),
        .syscfg_req_strb  (syscfg_req_strb),
        .syscfg_rsp_valid (syscfg_rsp_valid),
        .syscfg_rsp_rdata (syscfg_rsp_rdata),
        .syscfg_rsp_err   (syscfg_rsp_err),
        .lsp_req_valid    (lsp_req_valid),
        .lsp_req_ready    (lsp_req_ready),
        .lsp_req_addr     (lsp_req_addr),
        .lsp_req_we       (lsp_req_we),
        .lsp_req_wdata    (lsp_req_wdata),
        .lsp_req_strb     (lsp_req_strb),
        .lsp_rsp_valid    (lsp_rsp_valid),
        .lsp_rsp_rdata    (lsp_rsp_rdata),
        .lsp_rsp_err      (lsp_rsp_err),
        .cpu0_rsp_valid   (cpu0_rsp_valid),
        .cpu0_rsp_ready   (cpu0_rsp_ready),
        .cpu0_rsp_rdata   (cpu0_rsp_rdata),
        .cpu0_rsp_err     (cpu0_rsp_err),
        .cpu1_rsp_valid   (cpu1_rsp_valid),
        .cpu1_rsp_ready   (cpu1_rsp_ready),
        .cpu1_rsp_rdata   (cpu1_rsp_rdata),
        .cpu1_rsp_err     (cpu1_rsp_err)
    );

endmodule

/* lsdom_fabric_assertions.sv */
module lsdom_fabric_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             mem_req_valid,
    input logic             mem_req_ready,
    input logic             syscfg_req_valid,
    input logic             syscfg_req_ready,
    input logic             lsp_req_valid,
    input logic             lsp_req_ready,
    // Request payload is shared by all three targets
    input lsdom_pkg::addr_t req_addr,
    input logic             req_we,
    input lsdom_pkg::data_t req_wdata,
    input lsdom_pkg::strb_t req_strb,
    input logic             cpu0_rsp_valid,
    input logic             cpu0_rsp_ready,
    input logic             cpu1_rsp_valid,
    input logic             cpu1_rsp_ready
);
    logic stalled;

    assign stalled   = (mem_req_valid && !mem_req_ready) ||
                       (syscfg_req_valid && !syscfg_req_ready) ||
                       (lsp_req_valid && !lsp_req_ready);

    // The same target stays selected until it takes the request
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stalled |=> $stable({mem_req_valid, syscfg_req_valid, lsp_req_valid}) &&
                    $stable(req_addr) && $stable(req_we) &&
                    $stable(req_wdata) && $stable(req_strb))
        else $error("target request changed before its handshake");

    one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $countones({mem_req_valid, syscfg_req_valid, lsp_req_valid}) <= 1)
        else $error("more than one target request valid");

    cpu0_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu0_rsp_valid && !cpu0_rsp_ready) |=> cpu0_rsp_valid)
        else $error("cpu0 response dropped before rsp_ready");

    cpu1_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu1_rsp_valid && !cpu1_rsp_ready) |=> cpu1_rsp_valid)
        else $error("cpu1 response dropped before rsp_ready");

endmodule

/* lsdom_pkg.sv */
`include "lsdom_settings.svh"

package lsdom_pkg;

    typedef logic [`LSDOM_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`LSDOM_DATA_WIDTH-1:0]   data_t;
    // One enable per data byte
    typedef logic [`LSDOM_DATA_WIDTH/8-1:0] strb_t;

    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_SYSCFG,
        TGT_LSP,
        TGT_NONE
    } target_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RSP
    } router_state_e;

endpackage

/* lsdom_req_if.sv */
interface lsdom_req_if;
    import lsdom_pkg::*;

    logic    valid;
    logic    ready;
    // Offset within the selected region
    addr_t   addr;
    logic    we;
    data_t   wdata;
    strb_t   strb;
    target_e target;

    modport decoder (
        output valid,
        input  ready,
        output addr,
        output we,
        output wdata,
        output strb,
        output target
    );

    modport router (
        input  valid,
        output ready,
        input  addr,
        input  we,
        input  wdata,
        input  strb,
        input  target
    );

endinterface

/* lsdom_router.sv */
module lsdom_router (
    input  logic             clk,
    input  logic             rst_n,

    lsdom_req_if.router      dec0,
    lsdom_req_if.router      dec1,

    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output lsdom_pkg::addr_t mem_req_addr,
    output logic             mem_req_we,
    output lsdom_pkg::data_t mem_req_wdata,
    output lsdom_pkg::strb_t mem_req_strb,
    input  logic             mem_rsp_valid,
    input  lsdom_pkg::data_t mem_rsp_rdata,
    input  logic             mem_rsp_err,

    output logic             syscfg_req_valid,
    input  logic             syscfg_req_ready,
    output lsdom_pkg::addr_t syscfg_req_addr,
    output logic             syscfg_req_we,
    output lsdom_pkg::data_t syscfg_req_wdata,
    output lsdom_pkg::strb_t syscfg_req_strb,
    input  logic             syscfg_rsp_valid,
    input  lsdom_pkg::data_t syscfg_rsp_rdata,
    input  logic             syscfg_rsp_err,

    output logic             lsp_req_valid,
    input  logic             lsp_req_ready,
    output lsdom_pkg::addr_t lsp_req_addr,
    output logic             lsp_req_we,
    output lsdom_pkg::data_t lsp_req_wdata,
    output lsdom_pkg::strb_t lsp_req_strb,
    input  logic             lsp_rsp_valid,
    input  lsdom_pkg::data_t lsp_rsp_rdata,
    input  logic             lsp_rsp_err,

    output logic             cpu0_rsp_valid,
    input  logic             cpu0_rsp_ready,
    output lsdom_pkg::data_t cpu0_rsp_rdata,
    output logic             cpu0_rsp_err,

    output logic             cpu1_rsp_valid,
    input  logic             cpu1_rsp_ready,
    output lsdom_pkg::data_t cpu1_rsp_rdata,
    output logic             cpu1_rsp_err
);
    import lsdom_pkg::*;

    router_state_e state;
    target_e       tgt_q;
    logic          grant_q;
    // High when cpu1 won the last arbitration
    logic          last_grant;

    addr_t         addr_q;
    logic          we_q;
    data_t         wdata_q;
    strb_t         strb_q;
    data_t         rsp_rdata_q;
    logic          rsp_err_q;

    logic          win0;
    logic          win1;
    logic          accept;
    target_e       in_target;

    logic          sel_req_ready;
    logic          sel_rsp_valid;
    data_t         sel_rsp_rdata;
    logic          sel_rsp_err;
    logic          sel_cpu_ready;

    // Round-robin, the initiator not served last wins a tie
    assign win0   = dec0.valid && (!dec1.valid || last_grant);
    assign win1   = dec1.valid && (!dec0.valid || !last_grant);
    assign accept = (state == ST_IDLE) && (win0 || win1);

    assign dec0.ready = (state == ST_IDLE) && win0;
    assign dec1.ready = (state == ST_IDLE) && win1;
    assign in_target  = win1 ? dec1.target : dec0.target;

    always_comb begin
        sel_req_ready = 1'b0;
        sel_rsp_valid = 1'b0;
        sel_rsp_rdata = '0;
        sel_rsp_err   = 1'b0;
        case (tgt_q)
            TGT_MEM: begin
                sel_req_ready = mem_req_ready;
                sel_rsp_valid = mem_rsp_valid;
                sel_rsp_rdata = mem_rsp_rdata;
                sel_rsp_err   = mem_rsp_err;
            end
            TGT_SYSCFG: begin
                sel_req_ready = syscfg_req_ready;
                sel_rsp_valid = syscfg_rsp_valid;
                sel_rsp_rdata = syscfg_rsp_rdata;
                sel_rsp_err   = syscfg_rsp_err;
            end
            TGT_LSP: begin
                sel_req_ready = lsp_req_ready;
                sel_rsp_valid = lsp_rsp_valid;
                sel_rsp_rdata = lsp_rsp_rdata;
                sel_rsp_err   = lsp_rsp_err;
            end
            default: begin
            end
        endcase
    end

    assign sel_cpu_ready = grant_q ? cpu1_rsp_ready : cpu0_rsp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            tgt_q      <= TGT_NONE;
            grant_q    <= 1'b0;
            last_grant <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        tgt_q      <= in_target;
                        grant_q    <= win1;
                        last_grant <= win1;
                        state      <= (in_target == TGT_NONE) ? ST_RSP : ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sel_req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (sel_rsp_valid) begin
                        state <= ST_RSP;
                    end
                end
                ST_RSP: begin
                    if (sel_cpu_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q      <= win1 ? dec1.addr : dec0.addr;
            we_q        <= win1 ? dec1.we : dec0.we;
            wdata_q     <= win1 ? dec1.wdata : dec0.wdata;
            strb_q      <= win1 ? dec1.strb : dec0.strb;
            // Decode error answered without a target
            rsp_rdata_q <= '0;
            rsp_err_q   <= 1'b1;
        end else if (state == ST_WAIT && sel_rsp_valid) begin
            rsp_rdata_q <= sel_rsp_rdata;
            rsp_err_q   <= sel_rsp_err;
        end
    end

    assign mem_req_valid    = (state == ST_REQ) && (tgt_q == TGT_MEM);
    assign syscfg_req_valid = (state == ST_REQ) && (tgt_q == TGT_SYSCFG);
    assign lsp_req_valid    = (state == ST_REQ) && (tgt_q == TGT_LSP);

    // Payload is shared, valid picks the target
    assign mem_req_addr     = addr_q;
    assign mem_req_we       = we_q;
    assign mem_req_wdata    = wdata_q;
    assign mem_req_strb     = strb_q;
    assign syscfg_req_addr  = addr_q;
    assign syscfg_req_we    = we_q;
    assign syscfg_req_wdata = wdata_q;
    assign syscfg_req_strb  = strb_q;
    assign lsp_req_addr     = addr_q;
    assign lsp_req_we       = we_q;
    assign lsp_req_wdata    = wdata_q;
    assign lsp_req_strb     = strb_q;

    assign cpu0_rsp_valid = (state == ST_RSP) && !grant_q;
    assign cpu1_rsp_valid = (state == ST_RSP) && grant_q;
    assign cpu0_rsp_rdata = rsp_rdata_q;
    assign cpu1_rsp_rdata = rsp_rdata_q;
    assign cpu0_rsp_err   = rsp_err_q;
    assign cpu1_rsp_err   = rsp_err_q;

endmodule

/* lsdom_settings.svh */
`ifndef LSDOM_SETTINGS_SVH
`define LSDOM_SETTINGS_SVH

// Bus widths
`define LSDOM_ADDR_WIDTH 32
`define LSDOM_DATA_WIDTH 32

// Address map, end addresses exclusive
`define LSDOM_MEM_BASE    32'h0000_0000
`define LSDOM_MEM_END     32'h0000_8000

`define LSDOM_SYSCFG_BASE 32'h0000_8000
`define LSDOM_SYSCFG_END  32'h0000_8400

`define LSDOM_LSP_BASE    32'h0001_0000
`define LSDOM_LSP_END     32'h0002_0000

`endif

/* project.f */
+incdir+.
lsdom_pkg.sv
lsdom_req_if.sv
lsdom_decoder.sv
lsdom_router.sv
lsdom_fabric.sv
lsdom_fabric_assertions.sv
tb_lsdom_fabric.sv

/* tb_lsdom_fabric.sv */
module tb_lsdom_fabric;
    import lsdom_pkg::*;

    localparam int TOTAL_TXN  = 6 + 12 + 8 + 32 + 32;
    localparam int MAX_CYCLES = 200 * TOTAL_TXN;
    localparam int TGT_NONE_I = 3;

    logic  clk;
    logic  rst_n;
    logic  cpu_req_valid [2];
    logic  cpu_req_ready [2];
    addr_t cpu_req_addr  [2];
    logic  cpu_req_we    [2];
    data_t cpu_req_wdata [2];
    strb_t cpu_req_strb  [2];
    logic  cpu_rsp_valid [2];
    logic  cpu_rsp_ready [2];
    data_t cpu_rsp_rdata [2];
    logic  cpu_rsp_err   [2];
    logic  t_req_valid   [3];
    logic  t_req_ready   [3];
    addr_t t_req_addr    [3];
    logic  t_req_we      [3];
    data_t t_req_wdata   [3];
    strb_t t_req_strb    [3];
    logic  t_rsp_valid   [3];
    data_t t_rsp_rdata   [3];
    logic  t_rsp_err     [3];

    logic [31:0] rng_state = 32'd78;
    int    cycles = 0;
    int    errors = 0;
    int    issued = 0;
    int    done_cnt = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    err_start;
    int    done_start;
    int    gap_mode = 0;
    int    tgt_delay_max = 1;
    string cur_test = "reset";

    // In-flight transaction as the checker expects it
    logic  busy = 1'b0;
    int    inf_c;
    int    inf_tgt;
    addr_t inf_off;
    logic  inf_we;
    data_t inf_wdata;
    strb_t inf_strb;
    data_t inf_rdata;
    logic  inf_err;
    int    last_winner = 0;
    data_t sb_mem [longint];

    lsdom_fabric dut_i (
        .clk (clk), .rst_n (rst_n),
        .cpu0_req_valid (cpu_req_valid[0]), .cpu0_req_ready (cpu_req_ready[0]),
        .cpu0_req_addr (cpu_req_addr[0]), .cpu0_req_we (cpu_req_we[0]),
        .cpu0_req_wdata (cpu_req_wdata[0]), .cpu0_req_strb (cpu_req_strb[0]),
        .cpu0_rsp_valid (cpu_rsp_valid[0]), .cpu0_rsp_ready (cpu_rsp_ready[0]),
        .cpu0_rsp_rdata (cpu_rsp_rdata[0]), .cpu0_rsp_err (cpu_rsp_err[0]),
        .cpu1_req_valid (cpu_req_valid[1]), .cpu1_req_ready (cpu_req_ready[1]),
        .cpu1_req_addr (cpu_req_addr[1]), .cpu1_req_we (cpu_req_we[1]),
        .cpu1_req_wdata (cpu_req_wdata[1]), .cpu1_req_strb (cpu_req_strb[1]),
        .cpu1_rsp_valid (cpu_rsp_valid[1]), .cpu1_rsp_ready (cpu_rsp_ready[1]),
        .cpu1_rsp_rdata (cpu_rsp_rdata[1]), .cpu1_rsp_err (cpu_rsp_err[1]),
        .mem_req_valid (t_req_valid[0]), .mem_req_ready (t_req_ready[0]),
        .mem_req_addr (t_req_addr[0]), .mem_req_we (t_req_we[0]),
        .mem_req_wdata (t_req_wdata[0]), .mem_req_strb (t_req_strb[0]),
        .mem_rsp_valid (t_rsp_valid[0]), .mem_rsp_rdata (t_rsp_rdata[0]),
        .mem_rsp_err (t_rsp_err[0]),
        .syscfg_req_valid (t_req_valid[1]), .syscfg_req_ready (t_req_ready[1]),
        .syscfg_req_addr (t_req_addr[1]), .syscfg_req_we (t_req_we[1]),
        .syscfg_req_wdata (t_req_wdata[1]), .syscfg_req_strb (t_req_strb[1]),
        .syscfg_rsp_valid (t_rsp_valid[1]), .syscfg_rsp_rdata (t_rsp_rdata[1]),
        .syscfg_rsp_err (t_rsp_err[1]),
        .lsp_req_valid (t_req_valid[2]), .lsp_req_ready (t_req_ready[2]),
        .lsp_req_addr (t_req_addr[2]), .lsp_req_we (t_req_we[2]),
        .lsp_req_wdata (t_req_wdata[2]), .lsp_req_strb (t_req_strb[2]),
        .lsp_rsp_valid (t_rsp_valid[2]), .lsp_rsp_rdata (t_rsp_rdata[2]),
        .lsp_rsp_err (t_rsp_err[2])
    );

    bind lsdom_router lsdom_fabric_assertions assert_i (
        .clk (clk), .rst_n (rst_n),
        .mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
        .syscfg_req_valid (syscfg_req_valid), .syscfg_req_ready (syscfg_req_ready),
        .lsp_req_valid (lsp_req_valid), .lsp_req_ready (lsp_req_ready),
        .req_addr (mem_req_addr), .req_we (mem_req_we),
        .req_wdata (mem_req_wdata), .req_strb (mem_req_strb),
        .cpu0_rsp_valid (cpu0_rsp_valid), .cpu0_rsp_ready (cpu0_rsp_ready),
        .cpu1_rsp_valid (cpu1_rsp_valid), .cpu1_rsp_ready (cpu1_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected target index for an address, or 3 when unmapped
    function automatic int ref_decode(input addr_t a, output addr_t off);
        off = a;
        if (a < 32'h0000_8000) begin
            return 0;
        end
        if (a < 32'h0000_8400) begin
            off = a - 32'h0000_8000;
            return 1;
        end
        if (a >= 32'h0001_0000 && a < 32'h0002_0000) begin
            off = a - 32'h0001_0000;
            return 2;
        end
        return TGT_NONE_I;
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
        data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    function automatic longint word_key(input int t, input addr_t off);
        return (longint'(t) << 32) | longint'(off >> 2);
    endfunction

    // Regions 0 to 2 are mapped and 3 and 4 are the two unmapped ranges
    function automatic addr_t pick_addr(input int region);
        logic [31:0] r;
        r = rand32();
        case (region)
            0: return r & 32'h0000_7FFC;
            1: return 32'h0000_8000 + (r & 32'h0000_03FC);
            2: return 32'h0001_0000 + (r & 32'h0000_FFFC);
            3: return 32'h0000_8400 + ((r % 32'h0000_7C00) & 32'hFFFF_FFFC);
            default: return 32'h0002_0000 | (r & 32'hFFFF_FFFC);
        endcase
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("[ERROR] %s %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic report_msg(input string what);
        $display("Test %s: %s", cur_test, what);
        errors++;
    endtask

    // Byte-strobed target memories with random latency
    for (genvar t = 0; t < 3; t++) begin : tgt_g
        data_t tmem [longint];
        initial begin
            longint k;
            int     dly;
            t_req_ready[t] = 1'b0;
            t_rsp_valid[t] = 1'b0;
            t_rsp_rdata[t] = '0;
            t_rsp_err[t]   = 1'b0;
            forever begin
                @(negedge clk);
                if (t_req_valid[t]) begin
                    dly = int'(rand32() % 32'(tgt_delay_max + 1));
                    repeat (dly) @(negedge clk);
                    t_req_ready[t] = 1'b1;
                    @(posedge clk);
                    k = word_key(t, t_req_addr[t]);
                    if (!tmem.exists(k)) tmem[k] = '0;
                    if (t_req_we[t]) begin
                        tmem[k] = merge_bytes(tmem[k], t_req_wdata[t], t_req_strb[t]);
                    end
                    @(negedge clk);
                    t_req_ready[t] = 1'b0;
                    dly = int'(rand32() % 32'(tgt_delay_max + 1));
                    repeat (dly) @(negedge clk);
                    t_rsp_valid[t] = 1'b1;
                    t_rsp_rdata[t] = tmem[k];
                    @(negedge clk);
                    t_rsp_valid[t] = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a transaction never completed", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Compares the pre-edge values on each rising edge
    always @(posedge clk) begin : response_check
        addr_t  off;
        int     tgt;
        longint k;
        if (rst_n) begin
            for (int c = 0; c < 2; c++) begin
                if (cpu_rsp_valid[c] && cpu_rsp_ready[c]) begin
                    if (!busy || c != inf_c) begin
                        report_msg($sformatf("cpu%0d got a response it never asked for", c));
                    end else begin
                        if (cpu_rsp_err[c] !== inf_err)
                            report_value("rsp_err", 32'(inf_err), 32'(cpu_rsp_err[c]));
                        if (cpu_rsp_rdata[c] !== inf_rdata)
                            report_value("rsp_rdata", inf_rdata, cpu_rsp_rdata[c]);
                        busy = 1'b0;
                        done_cnt++;
                    end
                end
            end
            for (int t = 0; t < 3; t++) begin
                if (t_req_valid[t] && t_req_ready[t]) begin
                    if (!busy || inf_tgt != t) begin
                        report_msg($sformatf("target %0d saw a request meant elsewhere", t));
                    end else begin
                        if (t_req_addr[t] !== inf_off)
                            report_value("target addr", inf_off, t_req_addr[t]);
                        if (t_req_we[t] !== inf_we)
                            report_value("target we", 32'(inf_we), 32'(t_req_we[t]));
                        if (t_req_wdata[t] !== inf_wdata)
                            report_value("target wdata", inf_wdata, t_req_wdata[t]);
                        if (t_req_strb[t] !== inf_strb)
                            report_value("target strb", 32'(inf_strb), 32'(t_req_strb[t]));
                    end
                end
            end
            if (cpu_req_valid[0] && cpu_req_valid[1] && cpu_req_ready[last_winner])
                report_value("grant", 32'(1 - last_winner), 32'(last_winner));
            for (int c = 0; c < 2; c++) begin
                if (cpu_req_valid[c] && cpu_req_ready[c]) begin
                    if (busy) report_msg("request accepted while another is in flight");
                    tgt       = ref_decode(cpu_req_addr[c], off);
                    inf_c     = c;
                    inf_tgt   = tgt;
                    inf_off   = off;
                    inf_we    = cpu_req_we[c];
                    inf_wdata = cpu_req_wdata[c];
                    inf_strb  = cpu_req_strb[c];
                    inf_err   = (tgt == TGT_NONE_I);
                    inf_rdata = '0;
                    if (tgt != TGT_NONE_I) begin
                        k = word_key(tgt, off);
                        if (!sb_mem.exists(k)) sb_mem[k] = '0;
                        if (cpu_req_we[c])
                            sb_mem[k] = merge_bytes(sb_mem[k], cpu_req_wdata[c], cpu_req_strb[c]);
                        inf_rdata = sb_mem[k];
                    end
                    busy        = 1'b1;
                    last_winner = c;
                    issued++;
                end
            end
        end
    end

    // Starts on a falling edge and returns on one
    task automatic run_txn(input int c, input addr_t a, input logic we,
                           input data_t d, input strb_t s);
        logic done;
        cpu_req_valid[c] = 1'b1;
        cpu_req_addr[c]  = a;
        cpu_req_we[c]    = we;
        cpu_req_wdata[c] = d;
        cpu_req_strb[c]  = s;
        @(posedge clk);
        while (!cpu_req_ready[c]) @(posedge clk);
        @(negedge clk);
        cpu_req_valid[c] = 1'b0;
        done = 1'b0;
        while (!done) begin
            cpu_rsp_ready[c] = (gap_mode == 0) || (rand32() % 3 != 0);
            @(posedge clk);
            done = cpu_rsp_valid[c] && cpu_rsp_ready[c];
            if (!done) @(negedge clk);
        end
        @(negedge clk);
        cpu_rsp_ready[c] = 1'b0;
    endtask

    task automatic random_stream(input int c, input int n);
        for (int i = 0; i < n; i++) begin
            run_txn(c, pick_addr(int'(rand32() % 3)), rand32() % 2 == 0, rand32(),
                    strb_t'(rand32()));
        end
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        err_start  = errors;
        done_start = done_cnt;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != err_start) tests_failed++;
        $display("%-16s %0d transactions, %s", cur_test, done_cnt - done_start,
                 (errors == err_start) ? "ok" : "FAILED");
    endtask

    initial begin
        addr_t a;
        data_t d;
        rst_n = 1'b0;
        for (int c = 0; c < 2; c++) begin
            cpu_req_valid[c] = 1'b0;
            cpu_req_addr[c]  = '0;
            cpu_req_we[c]    = 1'b0;
            cpu_req_wdata[c] = '0;
            cpu_req_strb[c]  = '0;
            cpu_rsp_ready[c] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset");
        @(negedge clk);
        for (int c = 0; c < 2; c++) begin
            if (cpu_req_ready[c] || cpu_rsp_valid[c])
                report_msg($sformatf("cpu%0d ready or valid high after reset", c));
        end
        for (int t = 0; t < 3; t++) begin
            if (t_req_valid[t]) report_msg($sformatf("target %0d valid after reset", t));
        end
        finish_test();

        start_test("write_read");
        for (int r = 0; r < 3; r++) begin
            a = pick_addr(r);
            d = rand32();
            run_txn(r % 2, a, 1'b1, d, 4'hF);
            run_txn(r % 2, a, 1'b0, '0, '0);
        end
        finish_test();

        start_test("strobes");
        for (int r = 0; r < 3; r++) begin
            a = pick_addr(r);
            run_txn(0, a, 1'b1, rand32(), 4'hF);
            run_txn(1, a, 1'b1, rand32(), strb_t'(rand32()));
            run_txn(0, a, 1'b1, rand32(), strb_t'(rand32()));
            run_txn(1, a, 1'b0, '0, '0);
        end
        finish_test();

        start_test("unmapped");
        for (int i = 0; i < 8; i++) begin
            run_txn(i % 2, pick_addr(i < 4 ? 3 : 4), i % 3 == 0, rand32(), 4'hF);
        end
        finish_test();

        start_test("contention");
        fork
            random_stream(0, 16);
            random_stream(1, 16);
        join
        finish_test();

        start_test("backpressure");
        gap_mode      = 1;
        tgt_delay_max = 5;
        fork
            random_stream(0, 16);
            random_stream(1, 16);
        join
        finish_test();

        cur_test = "summary";
        if (busy || issued != done_cnt)
            report_msg($sformatf("%0d requests but %0d responses", issued, done_cnt));
        $display("%0d tests, %0d failed, %0d transactions, %0d errors",
                 tests_run, tests_failed, done_cnt, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
